// ==== rtl/exu_pkg.sv ====
/*
 * shared definitions for the two-stage execute unit
 *  - data, address and register index widths
 *  - operation codes
 *  - issued micro-op, segment entry and retired result records
 *  - reset values for the epoch bit and the segment register
 */
`default_nettype none

package exu_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    localparam word_t PC_RST      = '0;
    localparam word_t LINK_OFFSET = 32'd4;
    localparam logic  EPOCH_RST   = 1'b0;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_BEQ  = 4'd6,
        OP_BNE  = 4'd7,
        OP_BLT  = 4'd8,
        OP_BGE  = 4'd9,
        OP_JAL  = 4'd10,
        OP_JALR = 4'd11
    } exu_op_e;

    // operands arrive already resolved from the register file
    typedef struct packed {
        word_t    pc;
        exu_op_e  op;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        logic     use_imm;
        logic     epoch;
    } exu_uop_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        exu_op_e  op;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    target;
        logic     cmp_eq;
        logic     cmp_lt;
    } exu_seg_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     write_gpr;
        logic     taken;
        word_t    target;
    } exu_result_t;

    // bubble loaded on reset or flush
    localparam exu_seg_t SEG_EMPTY = '{
        valid:  1'b0,
        pc:     PC_RST,
        op:     OP_ADD,
        rd:     '0,
        a:      '0,
        b:      '0,
        target: '0,
        cmp_eq: 1'b0,
        cmp_lt: 1'b0
    };

endpackage

`default_nettype wire

// ==== rtl/exu_stage1.sv ====
/*
 * first execute half
 *  - input handshake and epoch filter for wrong-path micro-ops
 *  - operand b select, branch and jump target adder
 *  - equal and signed less-than compare flags
 */
`timescale 1ns/1ns
`default_nettype none

module exu_stage1 import exu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire exu_uop_t in_uop,
    input  wire logic     stall,
    input  wire logic     redirect,
    output logic          in_ready,
    output logic          seg_load,
    output exu_seg_t      seg_in
);

    logic  epoch_q;
    logic  accept;
    logic  epoch_ok;
    word_t target_base;
    word_t target_sum;

    assign in_ready = ~stall;
    assign accept   = in_valid & in_ready;
    assign epoch_ok = (in_uop.epoch == epoch_q);

    // a uop taken on the redirect edge is already wrong-path
    assign seg_load = accept & epoch_ok & ~redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            epoch_q <= EPOCH_RST;
        end else if (redirect) begin
            epoch_q <= ~epoch_q;
        end
    end

    // jalr is register relative, everything else pc relative
    assign target_base = (in_uop.op == OP_JALR) ? in_uop.rs1_data : in_uop.pc;
    assign target_sum  = target_base + in_uop.imm;

    always_comb begin
        seg_in.valid  = seg_load;
        seg_in.pc     = in_uop.pc;
        seg_in.op     = in_uop.op;
        seg_in.rd     = in_uop.rd;
        seg_in.a      = in_uop.rs1_data;
        seg_in.b      = in_uop.use_imm ? in_uop.imm : in_uop.rs2_data;
        seg_in.target = target_sum;
        if (in_uop.op == OP_JALR) begin
            seg_in.target = {target_sum[XLEN-1:1], 1'b0};
        end
        // compares always on the two register operands
        seg_in.cmp_eq = (in_uop.rs1_data == in_uop.rs2_data);
        seg_in.cmp_lt = ($signed(in_uop.rs1_data) < $signed(in_uop.rs2_data));
    end

    // issue side keeps a waiting uop in place
    a_in_held: assert property (
        @(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_uop)
    );

endmodule

`default_nettype wire

// ==== rtl/exu_seg.sv ====
/*
 * segment register between the two execute halves
 *  - holds one in-flight micro-op
 *  - freezes while the second half is stalled
 *  - loads a bubble on reset or on an unstalled flush
 */
`timescale 1ns/1ns
`default_nettype none

module exu_seg import exu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     seg_load,
    input  wire exu_seg_t seg_in,
    input  wire logic     stall,
    input  wire logic     redirect,
    output exu_seg_t      seg_q
);

    logic flush;

    // flush only takes effect once the pipe can move
    assign flush = redirect & ~stall;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            seg_q <= SEG_EMPTY;
        end else if (!stall) begin
            seg_q       <= seg_in;
            seg_q.valid <= seg_load;
        end
    end

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> $stable(seg_q)
    );

endmodule

`default_nettype wire

// ==== rtl/exu_stage2.sv ====
/*
 * second execute half
 *  - ALU result and link value
 *  - branch decision and redirect pulse
 *  - output register with valid/ready toward writeback
 *  - registered redirect aligned with the taken result
 */
`timescale 1ns/1ns
`default_nettype none

module exu_stage2 import exu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire exu_seg_t seg_q,
    input  wire logic     out_ready,
    output logic          stall,
    output logic          redirect,
    output logic          out_valid,
    output exu_result_t   out_result,
    output logic          redirect_valid,
    output word_t         redirect_pc
);

    logic        load;
    logic        taken;
    logic        writes;
    word_t       alu_value;
    word_t       link;
    exu_result_t res_d;

    assign stall = out_valid & ~out_ready;
    // output register empty or being drained this cycle
    assign load  = ~stall;

    assign link = seg_q.pc + LINK_OFFSET;

    always_comb begin
        alu_value = '0;
        taken     = 1'b0;
        writes    = 1'b1;
        case (seg_q.op)
            OP_ADD:  alu_value = seg_q.a + seg_q.b;
            OP_SUB:  alu_value = seg_q.a - seg_q.b;
            OP_AND:  alu_value = seg_q.a & seg_q.b;
            OP_OR:   alu_value = seg_q.a | seg_q.b;
            OP_XOR:  alu_value = seg_q.a ^ seg_q.b;
            OP_SLT: begin
                alu_value = {{(XLEN-1){1'b0}}, ($signed(seg_q.a) < $signed(seg_q.b))};
            end
            OP_BEQ: begin
                taken  = seg_q.cmp_eq;
                writes = 1'b0;
            end
            OP_BNE: begin
                taken  = ~seg_q.cmp_eq;
                writes = 1'b0;
            end
            OP_BLT: begin
                taken  = seg_q.cmp_lt;
                writes = 1'b0;
            end
            OP_BGE: begin
                taken  = ~seg_q.cmp_lt;
                writes = 1'b0;
            end
            OP_JAL, OP_JALR: begin
                taken     = 1'b1;
                alu_value = link;
            end
            default: writes = 1'b0;
        endcase
    end

    always_comb begin
        res_d.pc        = seg_q.pc;
        res_d.rd        = seg_q.rd;
        res_d.value     = alu_value;
        res_d.write_gpr = writes & (seg_q.rd != '0);
        res_d.taken     = taken;
        res_d.target    = seg_q.target;
    end

    // one-cycle pulse, only ever raised while the pipe moves
    assign redirect = load & seg_q.valid & taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= seg_q.valid;
            end
            redirect_valid <= redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_result <= res_d;
        end
        if (redirect) begin
            redirect_pc <= seg_q.target;
        end
    end

    a_result_held: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result)
    );

    // fetch sees the redirect together with its taken result
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (rst)
        redirect_valid |-> out_valid && out_result.taken
            && (redirect_pc == out_result.target)
    );

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
/*
 * execute unit top level
 *  - first half, segment register and second half in a chain
 *  - stall and redirect fed back from the second half
 */
`timescale 1ns/1ns
`default_nettype none

module exu_top import exu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire exu_uop_t in_uop,
    input  wire logic     out_ready,
    output logic          in_ready,
    output logic          out_valid,
    output exu_result_t   out_result,
    output logic          redirect_valid,
    output word_t         redirect_pc
);

    exu_seg_t seg_in;
    exu_seg_t seg_q;
    logic     seg_load;
    logic     stall;
    logic     redirect;

    exu_stage1 u_stage1 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_uop   (in_uop),
        .stall    (stall),
        .redirect (redirect),
        .in_ready (in_ready),
        .seg_load (seg_load),
        .seg_in   (seg_in)
    );

    exu_seg u_seg (
        .clk      (clk),
        .rst      (rst),
        .seg_load (seg_load),
        .seg_in   (seg_in),
        .stall    (stall),
        .redirect (redirect),
        .seg_q    (seg_q)
    );

    exu_stage2 u_stage2 (
        .clk            (clk),
        .rst            (rst),
        .seg_q          (seg_q),
        .out_ready      (out_ready),
        .stall          (stall),
        .redirect       (redirect),
        .out_valid      (out_valid),
        .out_result     (out_result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== include/exu_tb_vectors.svh ====
/*
 * stimulus and expected-value table for the execute unit testbench
 *  - table entry record and the table itself
 *  - one row per issued micro-op, in issue order
 */
`ifndef EXU_TB_VECTORS_SVH
`define EXU_TB_VECTORS_SVH

typedef struct {
    exu_uop_t    uop;
    logic        exp;
    exu_result_t res;
    logic        redir;
} vec_t;

vec_t vectors[$];

// flags: {use_imm, epoch, exp}, res_flags: {write_gpr, taken}
task automatic add_vec(word_t pc, exu_op_e op, reg_idx_t rd, word_t rs1, word_t rs2,
                       word_t imm, logic [2:0] flags, word_t value,
                       logic [1:0] res_flags, word_t target);
    vec_t v;
    v.uop           = '{pc, op, rd, rs1, rs2, imm, flags[2], flags[1]};
    v.exp           = flags[0];
    v.res           = '{pc, rd, value, res_flags[1], res_flags[0], target};
    v.redir         = flags[0] & res_flags[0];
    if (!flags[0]) begin
        v.res = '0;
    end
    vectors.push_back(v);
endtask

task automatic load_vectors();
    // alu, register and immediate forms
    add_vec(32'h100, OP_ADD, 5'd1, 32'd7, 32'd5, 32'd0, 3'b001, 32'd12, 2'b10, 32'h100);
    add_vec(32'h104, OP_SUB, 5'd2, 32'd5, 32'd7, 32'd0, 3'b001, 32'hFFFFFFFE, 2'b10, 32'h104);
    add_vec(32'h108, OP_AND, 5'd3, 32'hF0F0, 32'd0, 32'h0FF0, 3'b101, 32'h00F0, 2'b10, 32'h10F8);
    add_vec(32'h10C, OP_OR, 5'd4, 32'hF000, 32'h000F, 32'd0, 3'b001, 32'hF00F, 2'b10, 32'h10C);
    add_vec(32'h110, OP_XOR, 5'd5, 32'hFF, 32'd0, 32'h0F, 3'b101, 32'hF0, 2'b10, 32'h11F);
    add_vec(32'h114, OP_SLT, 5'd6, 32'hFFFFFFFF, 32'd1, 32'd0, 3'b001, 32'd1, 2'b10, 32'h114);
    add_vec(32'h118, OP_SLT, 5'd7, 32'd5, 32'd0, 32'hFFFFFFFE, 3'b101, 32'd0, 2'b10, 32'h116);
    add_vec(32'h11C, OP_ADD, 5'd0, 32'd3, 32'd0, 32'd4, 3'b101, 32'd7, 2'b00, 32'h120);
    // branches, each taken one followed by a wrong-path uop
    add_vec(32'h120, OP_BEQ, 5'd0, 32'd9, 32'd8, 32'h40, 3'b001, 32'd0, 2'b00, 32'h160);
    add_vec(32'h124, OP_BNE, 5'd0, 32'd9, 32'd8, 32'h20, 3'b001, 32'd0, 2'b01, 32'h144);
    add_vec(32'h128, OP_ADD, 5'd8, 32'd1, 32'd1, 32'd0, 3'b000, 32'd0, 2'b00, 32'd0);
    add_vec(32'h144, OP_BLT, 5'd0, 32'hFFFFFFF0, 32'd3, 32'h10, 3'b011, 32'd0, 2'b01, 32'h154);
    add_vec(32'h148, OP_XOR, 5'd9, 32'd1, 32'd2, 32'd0, 3'b010, 32'd0, 2'b00, 32'd0);
    add_vec(32'h154, OP_BGE, 5'd0, 32'hFFFFFFF0, 32'd3, 32'h8, 3'b001, 32'd0, 2'b00, 32'h15C);
    add_vec(32'h158, OP_BEQ, 5'd0, 32'd6, 32'd6, 32'hC, 3'b001, 32'd0, 2'b01, 32'h164);
    add_vec(32'h15C, OP_OR, 5'd12, 32'd1, 32'd2, 32'd0, 3'b000, 32'd0, 2'b00, 32'd0);
    // jumps
    add_vec(32'h164, OP_JAL, 5'd1, 32'd0, 32'd0, 32'h100, 3'b011, 32'h168, 2'b11, 32'h264);
    add_vec(32'h168, OP_ADD, 5'd13, 32'd4, 32'd4, 32'd0, 3'b010, 32'd0, 2'b00, 32'd0);
    add_vec(32'h264, OP_JALR, 5'd9, 32'h1001, 32'd0, 32'h10, 3'b001, 32'h268, 2'b11, 32'h1010);
    add_vec(32'h268, OP_SUB, 5'd14, 32'd9, 32'd1, 32'd0, 3'b000, 32'd0, 2'b00, 32'd0);
    add_vec(32'h1010, OP_ADD, 5'd10, 32'h7FFFFFFF, 32'd0, 32'd1, 3'b111, 32'h80000000, 2'b10,
            32'h1011);
    add_vec(32'h1014, OP_BGE, 5'd0, 32'd5, 32'd5, 32'h8, 3'b011, 32'd0, 2'b01, 32'h101C);
    add_vec(32'h1018, OP_ADD, 5'd15, 32'd2, 32'd2, 32'd0, 3'b010, 32'd0, 2'b00, 32'd0);
    add_vec(32'h101C, OP_SLT, 5'd11, 32'd3, 32'd7, 32'd0, 3'b001, 32'd1, 2'b10, 32'h101C);
endtask

`endif

// ==== sim/exu_tb.sv ====
/*
 * testbench for the execute unit
 *  - clock, reset and random out_ready back-pressure
 *  - table-driven issue of micro-ops
 *  - reference model for the table and in-order result monitor
 */
`timescale 1ns/1ns
`default_nettype none

module exu_tb import exu_pkg::*; ;

    `include "exu_tb_vectors.svh"

    localparam int HS_TIMEOUT  = 200;
    localparam int END_TIMEOUT = 2000;

    logic        clk;
    logic        rst;
    logic        in_valid;
    exu_uop_t    in_uop;
    logic        out_ready;
    logic        in_ready;
    logic        out_valid;
    exu_result_t out_result;
    logic        redirect_valid;
    word_t       redirect_pc;

    exu_result_t exp_q[$];
    logic        redir_q[$];
    int          got_count;
    logic        prev_valid;
    logic        prev_xfer;
    logic        fresh;

    exu_top u_exu_top (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_uop         (in_uop),
        .out_ready      (out_ready),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_result     (out_result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string what);
        stop_run($sformatf("[FAIL] %0t: %s", $time, what));
    endtask

    task automatic check_result(exu_result_t got, exu_result_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf(
                "result pc=%h rd=%0d value=%h wr=%b taken=%b target=%h, expected %h %0d %h %b %b %h",
                got.pc, got.rd, got.value, got.write_gpr, got.taken, got.target,
                exp.pc, exp.rd, exp.value, exp.write_gpr, exp.taken, exp.target));
        end
    endtask

    task automatic check_redirect(word_t got, word_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("redirect_pc %h, expected %h", got, exp));
        end
    endtask

    // result from the execute rules, used to vet the table
    function automatic exu_result_t model_result(exu_uop_t u);
        exu_result_t r;
        word_t       b;
        logic        wr;
        b        = u.use_imm ? u.imm : u.rs2_data;
        wr       = 1'b1;
        r.pc     = u.pc;
        r.rd     = u.rd;
        r.value  = '0;
        r.taken  = 1'b0;
        r.target = u.pc + u.imm;
        case (u.op)
            OP_ADD:  r.value = u.rs1_data + b;
            OP_SUB:  r.value = u.rs1_data - b;
            OP_AND:  r.value = u.rs1_data & b;
            OP_OR:   r.value = u.rs1_data | b;
            OP_XOR:  r.value = u.rs1_data ^ b;
            OP_SLT:  r.value = ($signed(u.rs1_data) < $signed(b)) ? 32'd1 : 32'd0;
            OP_JAL:  r.value = u.pc + 32'd4;
            OP_JALR: begin
                r.value  = u.pc + 32'd4;
                r.target = (u.rs1_data + u.imm) & ~32'd1;
            end
            default: wr = 1'b0;
        endcase
        case (u.op)
            OP_BEQ:  r.taken = (u.rs1_data == u.rs2_data);
            OP_BNE:  r.taken = (u.rs1_data != u.rs2_data);
            OP_BLT:  r.taken = ($signed(u.rs1_data) < $signed(u.rs2_data));
            OP_BGE:  r.taken = !($signed(u.rs1_data) < $signed(u.rs2_data));
            OP_JAL, OP_JALR: r.taken = 1'b1;
            default: r.taken = 1'b0;
        endcase
        r.write_gpr = wr && (u.rd != '0);
        return r;
    endfunction

    // epoch rule: a uop retires when its epoch matches the taken count
    task automatic build_expected();
        int   taken_cnt;
        logic produce;
        taken_cnt = 0;
        foreach (vectors[i]) begin
            produce = (vectors[i].uop.epoch == taken_cnt[0]);
            if (produce !== vectors[i].exp) begin
                stop_run($sformatf("table entry %0d breaks the epoch rule", i));
            end
            if (produce) begin
                if (model_result(vectors[i].uop) !== vectors[i].res) begin
                    stop_run($sformatf("table entry %0d disagrees with the model", i));
                end
                exp_q.push_back(vectors[i].res);
                redir_q.push_back(vectors[i].redir);
                if (vectors[i].res.taken) begin
                    taken_cnt++;
                end
            end
        end
    endtask

    // back-pressure
    initial begin
        out_ready = 1'b0;
        void'($urandom(49799));
        forever begin
            @(posedge clk);
            out_ready <= ($urandom % 4) != 0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            prev_valid = 1'b0;
            prev_xfer  = 1'b0;
        end else begin
            fresh = out_valid && (!prev_valid || prev_xfer);
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    stop_run("a result appeared that was never expected");
                end
                check_result(out_result, exp_q[0]);
                if (fresh && (redirect_valid !== redir_q[0])) begin
                    report_mismatch($sformatf("redirect_valid %b, expected %b",
                                              redirect_valid, redir_q[0]));
                end
                if (fresh && redir_q[0]) begin
                    check_redirect(redirect_pc, exp_q[0].target);
                end
                if (!fresh && redirect_valid) begin
                    report_mismatch("redirect_valid repeated on a held result");
                end
            end else if (redirect_valid) begin
                report_mismatch("redirect_valid without a result");
            end
            prev_valid = out_valid;
            prev_xfer  = out_valid && out_ready;
            if (prev_xfer) begin
                void'(exp_q.pop_front());
                void'(redir_q.pop_front());
                got_count++;
            end
        end
    end

    initial begin
        int total;
        int waited;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_uop    = '0;
        got_count = 0;
        load_vectors();
        build_expected();
        total = exp_q.size();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (out_valid !== 1'b0 || redirect_valid !== 1'b0 || in_ready !== 1'b1) begin
            report_mismatch("idle state after reset is wrong");
        end
        foreach (vectors[i]) begin
            in_valid <= 1'b1;
            in_uop   <= vectors[i].uop;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (waited > HS_TIMEOUT) begin
                    stop_run("timeout waiting for in_ready");
                end
            end while (in_ready !== 1'b1);
        end
        in_valid <= 1'b0;
        waited = 0;
        while (got_count < total) begin
            @(posedge clk);
            waited++;
            if (waited > END_TIMEOUT) begin
                stop_run("timeout waiting for the remaining results");
            end
        end
        // idle tail so a stray extra result is still caught
        repeat (20) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
rtl/exu_pkg.sv
rtl/exu_stage1.sv
rtl/exu_seg.sv
rtl/exu_stage2.sv
rtl/exu_top.sv
sim/exu_tb.sv

// ==== Makefile ====
# Verilator build and run for the execute unit testbench

VERILATOR ?= verilator
TOP       ?= exu_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) $(EXTRA) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# exit status of the binary is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
